/* dv/memExecTb.sv */
// Testbench for the memory execution stage top level.
// Drives random ops through five tests and checks outputs, cache read requests
// and the flush request against a reference model one cycle behind.

`default_nettype none

module memExecTb;
    timeunit 1ns;
    timeprecision 100ps;
    import memExecPkg::*;

    localparam int issueWidth     = 2;
    localparam int cyclesPerTest  = 40;
    localparam int numTests       = 5;
    localparam int drainCycles    = 4;
    localparam int watchdogCycles = 10 + numTests * (cyclesPerTest + drainCycles) + 40;

    logic         clk;
    logic         arstN;
    logic         inValid    [issueWidth];
    memExecInput  inOp       [issueWidth];
    operandPath   bypassData [issueWidth];
    logic         stall;
    logic         clear;
    logic         toRecoveryPhase;
    activeListPtr flushHeadPtr;
    activeListPtr flushTailPtr;
    logic         cacheFlushComplete;
    logic         outValid   [issueWidth];
    memExecOutput outOp      [issueWidth];
    logic         dcReadReq  [issueWidth];
    dataPath      dcReadAddr [issueWidth];
    logic         cacheFlushReq;

    int seed       = 32'h153b;
    int checkCount = 0;
    int errCount   = 0;

    // Model of the input register and the CSR file
    logic         modelValid [issueWidth];
    memExecInput  modelOp    [issueWidth];
    dataPath      csrModel   [4];
    logic         expValidQ  [$];
    memExecOutput expOpQ     [$];

    memExecTop #(
        .issueWidth (issueWidth)
    ) i_dut (
        .clk                (clk),
        .arstN              (arstN),
        .inValid            (inValid),
        .inOp               (inOp),
        .bypassData         (bypassData),
        .stall              (stall),
        .clear              (clear),
        .toRecoveryPhase    (toRecoveryPhase),
        .flushHeadPtr       (flushHeadPtr),
        .flushTailPtr       (flushTailPtr),
        .cacheFlushComplete (cacheFlushComplete),
        .outValid           (outValid),
        .outOp              (outOp),
        .dcReadReq          (dcReadReq),
        .dcReadAddr         (dcReadAddr),
        .cacheFlushReq      (cacheFlushReq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Expected tag-access payload of one lane
    function automatic memExecOutput predictLane(input memExecInput op, input logic lane0,
            input operandPath bypass, input logic flushDone, input dataPath csrOld);
        operandPath   a;
        operandPath   b;
        memExecOutput r;
        a = op.bypassA ? bypass : op.operandA;
        b = op.bypassB ? bypass : op.operandB;
        r.memOpInfo     = op.memOpInfo;
        r.activeListPtr = op.activeListPtr;
        r.addrOut       = a.data + 32'($signed(op.memOpInfo.addrIn));
        if (r.addrOut[31:28] == 4'h8) begin
            r.memRegion = REGION_MEMORY;
        end else if (r.addrOut[31:28] == 4'h4) begin
            r.memRegion = REGION_IO;
        end else begin
            r.memRegion = REGION_UNDEFINED;
        end
        r.regValid = (!op.memOpInfo.operandAIsReg || a.valid) &&
                     (!op.memOpInfo.operandBIsReg || b.valid);
        if (lane0 && op.memOpInfo.opType == OP_FENCE && op.memOpInfo.isFenceI && !flushDone) begin
            r.regValid = 1'b0;
        end
        r.dataIn = (lane0 && op.memOpInfo.opType == OP_CSR) ? csrOld : b.data;
        return r;
    endfunction

    always @(negedge clk) begin
        memExecOutput expOp;
        operandPath   opA;
        logic         expV;
        logic         flushed;
        logic         expReq;
        logic         fenceReq;
        dataPath      wdata;
        logic [1:0]   idx;
        if (!arstN) begin
            for (int l = 0; l < issueWidth; l++) begin
                modelValid[l] = 1'b0;
                modelOp[l]    = '0;
            end
            for (int r = 0; r < 4; r++) begin
                csrModel[r] = '0;
            end
            expValidQ.delete();
            expOpQ.delete();
        end else begin
            // Outputs for the ops predicted on the previous cycle
            if (expValidQ.size() >= issueWidth) begin
                for (int l = 0; l < issueWidth; l++) begin
                    expV  = expValidQ.pop_front();
                    expOp = expOpQ.pop_front();
                    checkCount++;
                    if (outValid[l] !== expV) begin
                        errCount++;
                        $display("Fail lane %0d outValid exp %h got %h", l, expV, outValid[l]);
                    end else if (expV && outOp[l] !== expOp) begin
                        errCount++;
                        $display("Fail lane %0d outOp exp %h got %h", l, expOp, outOp[l]);
                    end
                end
            end
            fenceReq = modelValid[0] && modelOp[0].memOpInfo.opType == OP_FENCE &&
                       modelOp[0].memOpInfo.isFenceI;
            checkCount++;
            if (cacheFlushReq !== fenceReq) begin
                errCount++;
                $display("Fail cacheFlushReq exp %h got %h", fenceReq, cacheFlushReq);
            end
            idx = modelOp[0].memOpInfo.addrIn[1:0];
            for (int l = 0; l < issueWidth; l++) begin
                flushed = toRecoveryPhase && flushRangeContains(modelOp[l].activeListPtr,
                                                                flushHeadPtr, flushTailPtr);
                expOp  = predictLane(modelOp[l], l == 0, bypassData[l], cacheFlushComplete,
                                     csrModel[idx]);
                expV   = modelValid[l] && !stall && !clear && !flushed;
                expReq = expV && expOp.regValid && modelOp[l].memOpInfo.opType == OP_LOAD;
                checkCount++;
                if (dcReadReq[l] !== expReq) begin
                    errCount++;
                    $display("Fail lane %0d dcReadReq exp %h got %h", l, expReq, dcReadReq[l]);
                end else if (expReq && dcReadAddr[l] !== expOp.addrOut) begin
                    errCount++;
                    $display("Fail lane %0d dcReadAddr exp %h got %h", l, expOp.addrOut,
                             dcReadAddr[l]);
                end
                expValidQ.push_back(expV);
                expOpQ.push_back(expOp);
                // CSR write lands at the coming edge
                if (l == 0 && expV && expOp.regValid &&
                        modelOp[0].memOpInfo.opType == OP_CSR) begin
                    opA   = modelOp[0].bypassA ? bypassData[0] : modelOp[0].operandA;
                    wdata = modelOp[0].memOpInfo.csrUseImm ?
                            {27'b0, modelOp[0].memOpInfo.csrImm} : opA.data;
                    case (modelOp[0].memOpInfo.csrCode)
                        CSR_WRITE: csrModel[idx] = wdata;
                        CSR_SET:   csrModel[idx] = csrModel[idx] | wdata;
                        CSR_CLEAR: csrModel[idx] = csrModel[idx] & ~wdata;
                        default:   ;
                    endcase
                end
            end
            if (!stall) begin
                for (int l = 0; l < issueWidth; l++) begin
                    modelValid[l] = clear ? 1'b0 : inValid[l];
                    modelOp[l]    = inOp[l];
                end
            end
        end
    end

    // Top nibble steered toward the memory and IO regions most of the time
    function automatic dataPath randomWord();
        dataPath w;
        w = $random(seed);
        case (w[1:0])
            2'd0:    w[31:28] = 4'h8;
            2'd1:    w[31:28] = 4'h4;
            default: ;
        endcase
        return w;
    endfunction

    function automatic memExecInput randomOp(input memOpType kind);
        logic [127:0] bits;
        memExecInput  op;
        bits = {$random(seed), $random(seed), $random(seed), $random(seed)};
        op = bits[$bits(memExecInput)-1:0];
        op.memOpInfo.opType   = kind;
        op.memOpInfo.isFenceI = (kind == OP_FENCE) && (bits[121:120] != 2'd0);
        if (op.memOpInfo.csrCode == 2'd3) begin
            op.memOpInfo.csrCode = CSR_WRITE;
        end
        op.operandA.data  = randomWord();
        op.operandA.valid = bits[127:126] != 2'd0;
        op.operandB.valid = bits[125:124] != 2'd0;
        return op;
    endfunction

    task automatic stepRandom(input int testId);
        memExecInput op;
        memOpType    kind;
        operandPath  byp;
        logic [31:0] rnd;
        @(posedge clk);
        for (int l = 0; l < issueWidth; l++) begin
            kind = (($random(seed) & 1) != 0) ? OP_LOAD : OP_STORE;
            if (l == 0 && testId == 4) kind = OP_CSR;
            if (l == 0 && testId == 5) kind = OP_FENCE;
            op         = randomOp(kind);
            byp.data   = randomWord();
            byp.valid  = ($random(seed) & 3) != 0;
            inOp[l]       <= op;
            inValid[l]    <= ($random(seed) & 3) != 0;
            bypassData[l] <= byp;
        end
        rnd = $random(seed);
        stall              <= (testId == 2) && (rnd[1:0] == 2'd0);
        clear              <= (testId == 2) && (rnd[4:2] == 3'd0);
        toRecoveryPhase    <= (testId == 3) && (rnd[7:6] != 2'd0);
        flushHeadPtr       <= rnd[12:8];
        flushTailPtr       <= rnd[17:13];
        cacheFlushComplete <= (testId == 5) && rnd[18];
    endtask

    task automatic stepIdle();
        @(posedge clk);
        for (int l = 0; l < issueWidth; l++) begin
            inValid[l] <= 1'b0;
        end
        stall              <= 1'b0;
        clear              <= 1'b0;
        toRecoveryPhase    <= 1'b0;
        cacheFlushComplete <= 1'b0;
    endtask

    task automatic runTest(input int testId, input string name);
        int startErr;
        startErr = errCount;
        repeat (cyclesPerTest) stepRandom(testId);
        repeat (drainCycles) stepIdle();
        $display("test %0d %s: %0d errors", testId, name, errCount - startErr);
    endtask

    initial begin
        arstN              <= 1'b0;
        stall              <= 1'b0;
        clear              <= 1'b0;
        toRecoveryPhase    <= 1'b0;
        flushHeadPtr       <= '0;
        flushTailPtr       <= '0;
        cacheFlushComplete <= 1'b0;
        for (int l = 0; l < issueWidth; l++) begin
            inValid[l]    <= 1'b0;
            inOp[l]       <= '0;
            bypassData[l] <= '0;
        end
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
        runTest(1, "loads and stores");
        runTest(2, "stall and clear");
        runTest(3, "selective flush");
        runTest(4, "csr access");
        runTest(5, "fence.i");
        $display("checks %0d errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * 4);
        $display("Timeout, the tests did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/csrFile.sv */
// Small control/status register file for the memory pipe.
// Four 32-bit registers picked by the low bits of the CSR number.
// Reads are combinational; writes apply write, set-bits or clear-bits.

`default_nettype none

module csrFile (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire logic                csrWriteEnable,
    input  wire logic [11:0]         csrNumber,
    input  wire memExecPkg::dataPath csrWriteData,
    input  wire memExecPkg::csrCode  csrCode,
    output memExecPkg::dataPath      csrReadData
);
    import memExecPkg::*;

    dataPath    csrRegs [4];
    dataPath    nextValue;
    logic [1:0] csrIndex;

    assign csrIndex    = csrNumber[1:0];
    assign csrReadData = csrRegs[csrIndex];

    // Read-modify-write value for the selected register
    always_comb begin
        case (csrCode)
            CSR_WRITE: nextValue = csrWriteData;
            CSR_SET:   nextValue = csrRegs[csrIndex] | csrWriteData;
            CSR_CLEAR: nextValue = csrRegs[csrIndex] & ~csrWriteData;
            default:   nextValue = csrRegs[csrIndex];
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 4; i++) begin
                csrRegs[i] <= '0;
            end
        end else if (csrWriteEnable) begin
            csrRegs[csrIndex] <= nextValue;
        end
    end

endmodule

`default_nettype wire

/* hw/memExecPkg.sv */
// Shared types for the memory execution stage and its testbench.
// Defines the op descriptor, the two pipeline payloads, the address region
// encoding and the selective flush range check.

`default_nettype none

package memExecPkg;

    typedef logic [31:0] dataPath;
    typedef logic [4:0]  activeListPtr;

    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_CSR   = 2'd2,
        OP_FENCE = 2'd3
    } memOpType;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'd0,
        CSR_SET   = 2'd1,
        CSR_CLEAR = 2'd2
    } csrCode;

    // Decoded from the top nibble of the address
    typedef enum logic [1:0] {
        REGION_MEMORY    = 2'd0,
        REGION_IO        = 2'd1,
        REGION_UNDEFINED = 2'd2
    } memRegionType;

    typedef struct packed {
        memOpType    opType;
        logic [11:0] addrIn;        // Immediate, or CSR number for CSR ops
        logic        operandAIsReg;
        logic        operandBIsReg;
        logic        isFenceI;
        csrCode      csrCode;
        logic        csrUseImm;
        logic [4:0]  csrImm;
    } memOpInfo;

    // Data word with its ready bit
    typedef struct packed {
        dataPath data;
        logic    valid;
    } operandPath;

    typedef struct packed {
        memOpInfo     memOpInfo;
        activeListPtr activeListPtr;
        operandPath   operandA;
        operandPath   operandB;
        logic         bypassA;
        logic         bypassB;
    } memExecInput;

    typedef struct packed {
        memOpInfo     memOpInfo;
        activeListPtr activeListPtr;
        dataPath      addrOut;
        dataPath      dataIn;
        logic         regValid;
        memRegionType memRegion;
    } memExecOutput;

    // Circular range [head, tail) that is empty when head equals tail
    function automatic logic flushRangeContains(
        input activeListPtr ptr,
        input activeListPtr head,
        input activeListPtr tail
    );
        if (head <= tail) begin
            return (ptr >= head) && (ptr < tail);
        end
        return (ptr >= head) || (ptr < tail);
    endfunction

endpackage

`default_nettype wire

/* hw/memExecTop.sv */
// Top level of the memory execution stage.
// Input register, combinational stage with its CSR file, and the
// tag-access register that is never stalled.

`default_nettype none

module memExecTop #(
    parameter int issueWidth = 2
) (
    input  wire logic                     clk,
    input  wire logic                     arstN,
    input  wire logic                     inValid    [issueWidth],
    input  wire memExecPkg::memExecInput  inOp       [issueWidth],
    input  wire memExecPkg::operandPath   bypassData [issueWidth],
    input  wire logic                     stall,
    input  wire logic                     clear,
    input  wire logic                     toRecoveryPhase,
    input  wire memExecPkg::activeListPtr flushHeadPtr,
    input  wire memExecPkg::activeListPtr flushTailPtr,
    input  wire logic                     cacheFlushComplete,
    output logic                          outValid   [issueWidth],
    output memExecPkg::memExecOutput      outOp      [issueWidth],
    output logic                          dcReadReq  [issueWidth],
    output memExecPkg::dataPath           dcReadAddr [issueWidth],
    output logic                          cacheFlushReq
);
    import memExecPkg::*;

    logic         pipeValid [issueWidth];
    memExecInput  pipeOp    [issueWidth];
    logic         nextValid [issueWidth];
    memExecOutput nextOp    [issueWidth];

    logic         csrWriteEnable;
    logic [11:0]  csrNumber;
    dataPath      csrWriteData;
    dataPath      csrReadData;
    csrCode       csrOpCode;

    pipeStageRegister #(
        .payloadType (memExecInput),
        .width       (issueWidth)
    ) i_inReg (
        .clk        (clk),
        .arstN      (arstN),
        .hold       (stall),
        .clear      (clear),
        .validIn    (inValid),
        .payloadIn  (inOp),
        .validOut   (pipeValid),
        .payloadOut (pipeOp)
    );

    memoryExecutionStage #(
        .issueWidth (issueWidth)
    ) i_stage (
        .pipeValid          (pipeValid),
        .pipeOp             (pipeOp),
        .bypassData         (bypassData),
        .stall              (stall),
        .clear              (clear),
        .toRecoveryPhase    (toRecoveryPhase),
        .flushHeadPtr       (flushHeadPtr),
        .flushTailPtr       (flushTailPtr),
        .cacheFlushComplete (cacheFlushComplete),
        .csrReadData        (csrReadData),
        .csrWriteEnable     (csrWriteEnable),
        .csrNumber          (csrNumber),
        .csrWriteData       (csrWriteData),
        .csrCode            (csrOpCode),
        .dcReadReq          (dcReadReq),
        .dcReadAddr         (dcReadAddr),
        .cacheFlushReq      (cacheFlushReq),
        .nextValid          (nextValid),
        .nextOp             (nextOp)
    );

    csrFile i_csrFile (
        .clk            (clk),
        .arstN          (arstN),
        .csrWriteEnable (csrWriteEnable),
        .csrNumber      (csrNumber),
        .csrWriteData   (csrWriteData),
        .csrCode        (csrOpCode),
        .csrReadData    (csrReadData)
    );

    // Output side loads every cycle and takes its bubbles from the stage
    pipeStageRegister #(
        .payloadType (memExecOutput),
        .width       (issueWidth)
    ) i_outReg (
        .clk        (clk),
        .arstN      (arstN),
        .hold       (1'b0),
        .clear      (1'b0),
        .validIn    (nextValid),
        .payloadIn  (nextOp),
        .validOut   (outValid),
        .payloadOut (outOp)
    );

endmodule

`default_nettype wire

/* hw/memoryExecutionStage.sv */
// Combinational part of the memory execution stage.
// Picks bypassed operands, forms the address, decodes its region and decides
// replay and flush per lane. Lane 0 also drives the CSR file and FENCE.I.

`default_nettype none

module memoryExecutionStage #(
    parameter int issueWidth = 2
) (
    input  wire logic                     pipeValid  [issueWidth],
    input  wire memExecPkg::memExecInput  pipeOp     [issueWidth],
    input  wire memExecPkg::operandPath   bypassData [issueWidth],
    input  wire logic                     stall,
    input  wire logic                     clear,
    input  wire logic                     toRecoveryPhase,
    input  wire memExecPkg::activeListPtr flushHeadPtr,
    input  wire memExecPkg::activeListPtr flushTailPtr,
    input  wire logic                     cacheFlushComplete,
    input  wire memExecPkg::dataPath      csrReadData,
    output logic                          csrWriteEnable,
    output logic [11:0]                   csrNumber,
    output memExecPkg::dataPath           csrWriteData,
    output memExecPkg::csrCode            csrCode,
    output logic                          dcReadReq  [issueWidth],
    output memExecPkg::dataPath           dcReadAddr [issueWidth],
    output logic                          cacheFlushReq,
    output logic                          nextValid  [issueWidth],
    output memExecPkg::memExecOutput      nextOp     [issueWidth]
);
    import memExecPkg::*;

    memOpInfo     opInfo    [issueWidth];
    operandPath   fuOpA     [issueWidth];
    operandPath   fuOpB     [issueWidth];
    dataPath      addrOut   [issueWidth];
    memRegionType memRegion [issueWidth];
    logic         regValid  [issueWidth];
    logic         flush     [issueWidth];
    logic         isCsr;

    always_comb begin
        for (int i = 0; i < issueWidth; i++) begin
            opInfo[i] = pipeOp[i].memOpInfo;
            flush[i]  = toRecoveryPhase &&
                flushRangeContains(pipeOp[i].activeListPtr, flushHeadPtr, flushTailPtr);

            // Bypass network wins when flagged
            fuOpA[i] = pipeOp[i].bypassA ? bypassData[i] : pipeOp[i].operandA;
            fuOpB[i] = pipeOp[i].bypassB ? bypassData[i] : pipeOp[i].operandB;

            addrOut[i] = fuOpA[i].data +
                {{20{opInfo[i].addrIn[11]}}, opInfo[i].addrIn};

            case (addrOut[i][31:28])
                4'h8:    memRegion[i] = REGION_MEMORY;
                4'h4:    memRegion[i] = REGION_IO;
                default: memRegion[i] = REGION_UNDEFINED;
            endcase

            // Not-ready register operand means the op is replayed later
            regValid[i] = (!opInfo[i].operandAIsReg || fuOpA[i].valid) &&
                          (!opInfo[i].operandBIsReg || fuOpB[i].valid);
        end

        // FENCE.I lives in lane 0 and waits for the cache flush to finish
        cacheFlushReq = 1'b0;
        if (pipeValid[0] && opInfo[0].opType == OP_FENCE && opInfo[0].isFenceI) begin
            cacheFlushReq = 1'b1;
            if (!cacheFlushComplete) begin
                regValid[0] = 1'b0;
            end
        end

        for (int i = 0; i < issueWidth; i++) begin
            dcReadReq[i] = !stall && !clear && pipeValid[i] && regValid[i] &&
                           !flush[i] && opInfo[i].opType == OP_LOAD;
            dcReadAddr[i] = addrOut[i];
        end
    end

    // CSR access from lane 0 only
    always_comb begin
        isCsr          = opInfo[0].opType == OP_CSR;
        csrWriteEnable = pipeValid[0] && isCsr && regValid[0] && !flush[0] &&
                         !stall && !clear;
        csrNumber      = opInfo[0].addrIn;
        csrWriteData   = opInfo[0].csrUseImm ? {27'b0, opInfo[0].csrImm} : fuOpA[0].data;
        csrCode        = opInfo[0].csrCode;
    end

    // Payload for the tag-access register
    always_comb begin
        for (int i = 0; i < issueWidth; i++) begin
            nextValid[i] = (stall || clear || flush[i]) ? 1'b0 : pipeValid[i];

            nextOp[i].memOpInfo     = opInfo[i];
            nextOp[i].activeListPtr = pipeOp[i].activeListPtr;
            nextOp[i].addrOut       = addrOut[i];
            nextOp[i].dataIn        = fuOpB[i].data;
            nextOp[i].regValid      = regValid[i];
            nextOp[i].memRegion     = memRegion[i];
        end

        // A CSR op returns the value held before its write
        if (isCsr) begin
            nextOp[0].dataIn = csrReadData;
        end
    end

endmodule

`default_nettype wire

/* hw/pipeStageRegister.sv */
// Per-lane pipeline register shared by both stage boundaries.
// The payload type is a parameter; valid bits reset, the payload does not.
// Hold freezes the contents, clear empties the valid bits on a load.

`default_nettype none

module pipeStageRegister #(
    parameter type payloadType = logic,
    parameter int  width       = 1
) (
    input  wire logic       clk,
    input  wire logic       arstN,
    input  wire logic       hold,
    input  wire logic       clear,
    input  wire logic       validIn    [width],
    input  wire payloadType payloadIn  [width],
    output logic            validOut   [width],
    output payloadType      payloadOut [width]
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < width; i++) begin
                validOut[i] <= 1'b0;
            end
        end else if (!hold) begin
            for (int i = 0; i < width; i++) begin
                validOut[i] <= clear ? 1'b0 : validIn[i];
            end
        end
    end

    // Payload loads together with the valid bits
    always_ff @(posedge clk) begin
        if (!hold) begin
            for (int i = 0; i < width; i++) begin
                payloadOut[i] <= payloadIn[i];
            end
        end
    end

endmodule

`default_nettype wire

/* memExecTop.f */
hw/memExecPkg.sv
hw/pipeStageRegister.sv
hw/csrFile.sv
hw/memoryExecutionStage.sv
hw/memExecTop.sv
dv/memExecTb.sv

/* runSim.sh */
#!/bin/sh
# Builds the memory execution stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f memExecTop.f \
    --top-module memExecTb -o memExecSim || exit 1
simOut="$(./obj_dir/memExecSim)"
echo "$simOut"
echo "$simOut" | grep -qF '*** PASSED ***' && exit 0 || exit 1
